// ==== hdl/isaPkg.sv ====
// ========================================
// MIPS32 ISA subset definitions
// opcodes, function codes, instruction formats
// ========================================
package isaPkg;

    // primary opcode field, bits 31..26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,     // R-type, decoded by funct
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeE;

    // funct field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functE;

    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;    // unused by this subset
        functE       funct;
    } rTypeT;

    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef struct packed {
        opcodeE      opcode;
        logic [25:0] index;    // word index inside the 256 MB region
    } jTypeT;

    // one fetched word, viewed by format
    typedef union packed {
        rTypeT r;
        iTypeT i;
        jTypeT j;
    } instrU;

    localparam logic [31:0] NOP_WORD = 32'h0000_0000;
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

// ==== hdl/pipePkg.sv ====
// ========================================
// pipeline types for the five-stage core
// control bundle, stage registers, trace
// ========================================
package pipePkg;

    import isaPkg::*;

    localparam int REG_COUNT = 32;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,     // must stay zero, a cleared bundle is a NOP
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } aluOpE;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2,
        BR_JUMP = 2'd3
    } branchE;

    typedef struct packed {
        aluOpE  aluOp;
        logic   aluSrcImm;    // operand B from immediate
        logic   immZero;      // zero-extend immediate
        logic   regWrite;
        logic   dstIsRt;      // I-type destination
        logic   memRead;
        logic   memWrite;
        branchE branch;
    } ctrlT;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwdSelE;

    typedef struct packed {
        logic        valid;
        logic [31:0] pcPlus4;
        instrU       instr;
    } ifIdT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pcPlus4;
        ctrlT        ctrl;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] imm;
        logic [25:0] jIndex;
    } idExT;

    typedef struct packed {
        logic        valid;
        ctrlT        ctrl;
        logic [4:0]  dst;
        logic [31:0] aluOut;     // also the memory address
        logic [31:0] storeData;
    } exMemT;

    typedef struct packed {
        logic        valid;
        ctrlT        ctrl;
        logic [4:0]  dst;
        logic [31:0] aluOut;
        logic [31:0] loadData;
    } memWbT;

    typedef struct packed {
        logic        valid;
        logic [4:0]  dst;
        logic [31:0] data;
    } traceT;

endpackage

// ==== hdl/regFile.sv ====
// ========================================
// 32 x 32 register file, r0 reads zero
// ========================================
`timescale 1ns/1ps

module regFile import pipePkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [4:0]  rdAddrA_i,
    input  logic [4:0]  rdAddrB_i,
    output logic [31:0] rdDataA_o,
    output logic [31:0] rdDataB_o,
    input  logic        wrEn_i,
    input  logic [4:0]  wrAddr_i,
    input  logic [31:0] wrData_i
);

    logic [31:0] regs [REG_COUNT];

    // same-cycle write is seen by decode
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) return 32'd0;
        if (wrEn_i && wrAddr_i == addr) return wrData_i;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int n = 0; n < REG_COUNT; n++) begin
                regs[n] <= '0;
            end
        end else if (wrEn_i && wrAddr_i != 5'd0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    assign rdDataA_o = readPort(rdAddrA_i);
    assign rdDataB_o = readPort(rdAddrB_i);

    wrAddrKnown: assert property (@(posedge clk) disable iff (reset_i)
        wrEn_i |-> !$isunknown(wrAddr_i));

endmodule

// ==== hdl/decodeUnit.sv ====
// ========================================
// instruction decoder
// builds control bundle and immediate
// ========================================
`timescale 1ns/1ps

module decodeUnit import isaPkg::*; import pipePkg::*; (
    input  instrU       instr_i,
    output ctrlT        ctrl_o,
    output logic [31:0] imm_o,
    output logic        legal_o
);

    always_comb begin
        ctrl_o  = '0;
        legal_o = 1'b1;
        case (instr_i.r.opcode)
            OP_SPECIAL: begin
                ctrl_o.regWrite = 1'b1;     // rd destination
                case (instr_i.r.funct)
                    FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    FN_AND:  ctrl_o.aluOp = ALU_AND;
                    FN_OR:   ctrl_o.aluOp = ALU_OR;
                    FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    default: begin
                        ctrl_o  = '0;
                        legal_o = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.aluOp     = ALU_ADD;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.dstIsRt   = 1'b1;
            end
            OP_ORI: begin
                ctrl_o.aluOp     = ALU_OR;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.immZero   = 1'b1;
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.dstIsRt   = 1'b1;
            end
            OP_LUI: begin
                ctrl_o.aluOp     = ALU_LUI;     // passes the shifted immediate
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.dstIsRt   = 1'b1;
            end
            OP_LW: begin
                ctrl_o.aluSrcImm = 1'b1;        // base plus offset
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.dstIsRt   = 1'b1;
                ctrl_o.memRead   = 1'b1;
            end
            OP_SW: begin
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.memWrite  = 1'b1;
            end
            OP_BEQ:  ctrl_o.branch = BR_EQ;
            OP_BNE:  ctrl_o.branch = BR_NE;
            OP_J:    ctrl_o.branch = BR_JUMP;
            default: legal_o = 1'b0;
        endcase
    end

    always_comb begin
        if (instr_i.i.opcode == OP_LUI) begin
            imm_o = {instr_i.i.imm, 16'h0000};
        end else if (ctrl_o.immZero) begin
            imm_o = {16'h0000, instr_i.i.imm};
        end else begin
            imm_o = {{16{instr_i.i.imm[15]}}, instr_i.i.imm};
        end
    end

endmodule

// ==== hdl/hazardUnit.sv ====
// ========================================
// forwarding selects and load-use stall
// ========================================
`timescale 1ns/1ps

module hazardUnit import pipePkg::*; (
    input  idExT       idEx_i,
    input  exMemT      exMem_i,
    input  memWbT      memWb_i,
    input  logic [4:0] ifIdRs_i,
    input  logic [4:0] ifIdRt_i,
    output fwdSelE     fwdA_o,
    output fwdSelE     fwdB_o,
    output logic       stall_o
);

    logic loadInEx;

    // memory stage holds the younger result, so it is checked first
    function automatic fwdSelE pickFwd(input logic [4:0] src);
        if (src == 5'd0) begin
            return FWD_REG;     // r0 is never forwarded
        end
        if (exMem_i.valid && exMem_i.ctrl.regWrite && exMem_i.dst == src) begin
            return FWD_MEM;
        end
        if (memWb_i.valid && memWb_i.ctrl.regWrite && memWb_i.dst == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwdA_o = pickFwd(idEx_i.rs);
    assign fwdB_o = pickFwd(idEx_i.rt);

    assign loadInEx = idEx_i.valid && idEx_i.ctrl.memRead && idEx_i.dst != 5'd0;

    // load data only exists in memory stage, one bubble is enough
    assign stall_o = loadInEx && (idEx_i.dst == ifIdRs_i || idEx_i.dst == ifIdRt_i);

    // a stalling load never carries a branch, so a taken flush cannot coincide
    always_comb begin
        stallNotOnBranch: assert final (!stall_o || idEx_i.ctrl.branch == BR_NONE)
            else $error("load-use stall raised with a branch in execute");
    end

endmodule

// ==== hdl/executeUnit.sv ====
// ========================================
// execute stage: operand forwarding, ALU
// and branch/jump resolution
// ========================================
`timescale 1ns/1ps

module executeUnit import pipePkg::*; (
    input  idExT        idEx_i,
    input  fwdSelE      fwdA_i,
    input  fwdSelE      fwdB_i,
    input  logic [31:0] memResult_i,
    input  logic [31:0] wbResult_i,
    output logic [31:0] aluOut_o,
    output logic [31:0] storeData_o,
    output logic        taken_o,
    output logic [31:0] target_o
);

    logic [31:0] rsFwd;
    logic [31:0] rtFwd;
    logic [31:0] opB;

    function automatic logic [31:0] pickSrc(input fwdSelE sel, input logic [31:0] regVal);
        case (sel)
            FWD_MEM: return memResult_i;
            FWD_WB:  return wbResult_i;
            default: return regVal;
        endcase
    endfunction

    assign rsFwd       = pickSrc(fwdA_i, idEx_i.rsVal);
    assign rtFwd       = pickSrc(fwdB_i, idEx_i.rtVal);
    assign opB         = idEx_i.ctrl.aluSrcImm ? idEx_i.imm : rtFwd;
    assign storeData_o = rtFwd;     // SW data is rt after forwarding

    always_comb begin
        case (idEx_i.ctrl.aluOp)
            ALU_ADD: aluOut_o = rsFwd + opB;
            ALU_SUB: aluOut_o = rsFwd - opB;
            ALU_AND: aluOut_o = rsFwd & opB;
            ALU_OR:  aluOut_o = rsFwd | opB;
            ALU_SLT: aluOut_o = {31'd0, $signed(rsFwd) < $signed(opB)};
            ALU_LUI: aluOut_o = opB;
            default: aluOut_o = rsFwd + opB;
        endcase
    end

    // bubbles carry a cleared bundle, so no valid gating here
    always_comb begin
        case (idEx_i.ctrl.branch)
            BR_EQ:   taken_o = (rsFwd == rtFwd);
            BR_NE:   taken_o = (rsFwd != rtFwd);
            BR_JUMP: taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    always_comb begin
        if (idEx_i.ctrl.branch == BR_JUMP) begin
            target_o = {idEx_i.pcPlus4[31:28], idEx_i.jIndex, 2'b00};
        end else begin
            target_o = idEx_i.pcPlus4 + {idEx_i.imm[29:0], 2'b00};   // offset in words
        end
    end

    // holds only if the core clears the bundle on every bubble and flush
    always_comb begin
        takenOnlyValid: assert final (!taken_o || idEx_i.valid)
            else $error("branch taken by an invalid execute entry");
    end

endmodule

// ==== hdl/mipsCore.sv ====
// ========================================
// five-stage MIPS32 integer core
// ========================================
`timescale 1ns/1ps

module mipsCore import isaPkg::*; import pipePkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    output logic [31:0] imemAddr_o,
    input  logic [31:0] imemInstr_i,
    output logic [31:0] dmemAddr_o,
    output logic        dmemWe_o,
    output logic [31:0] dmemWdata_o,
    input  logic [31:0] dmemRdata_i,
    output traceT       trace_o
);

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    ifIdT        ifId;
    idExT        idEx;
    exMemT       exMem;
    memWbT       memWb;
    idExT        idExNext;

    ctrlT        decCtrl;
    logic [31:0] decImm;
    logic        decLegal;
    logic        decValid;
    logic [31:0] rfDataA;
    logic [31:0] rfDataB;
    fwdSelE      fwdA;
    fwdSelE      fwdB;
    logic        stall;
    logic [31:0] aluOut;
    logic [31:0] storeData;
    logic        taken;
    logic [31:0] target;
    logic [31:0] wbResult;
    logic        wbEn;

    assign pcPlus4    = pc + 32'd4;
    assign imemAddr_o = pc;

    decodeUnit uDecode (
        .instr_i (ifId.instr),
        .ctrl_o  (decCtrl),
        .imm_o   (decImm),
        .legal_o (decLegal)
    );

    regFile uRegFile (
        .clk       (clk),
        .reset_i   (reset_i),
        .rdAddrA_i (ifId.instr.r.rs),
        .rdAddrB_i (ifId.instr.r.rt),
        .rdDataA_o (rfDataA),
        .rdDataB_o (rfDataB),
        .wrEn_i    (wbEn),
        .wrAddr_i  (memWb.dst),
        .wrData_i  (wbResult)
    );

    // illegal words continue as NOPs
    assign decValid = ifId.valid && decLegal;

    always_comb begin
        idExNext.valid   = decValid;
        idExNext.pcPlus4 = ifId.pcPlus4;
        idExNext.ctrl    = decValid ? decCtrl : '0;
        idExNext.rs      = ifId.instr.r.rs;
        idExNext.rt      = ifId.instr.r.rt;
        idExNext.dst     = decCtrl.dstIsRt ? ifId.instr.r.rt : ifId.instr.r.rd;
        idExNext.rsVal   = rfDataA;
        idExNext.rtVal   = rfDataB;
        idExNext.imm     = decImm;
        idExNext.jIndex  = ifId.instr.j.index;
    end

    hazardUnit uHazard (
        .idEx_i   (idEx),
        .exMem_i  (exMem),
        .memWb_i  (memWb),
        .ifIdRs_i (ifId.instr.r.rs),
        .ifIdRt_i (ifId.instr.r.rt),
        .fwdA_o   (fwdA),
        .fwdB_o   (fwdB),
        .stall_o  (stall)
    );

    executeUnit uExecute (
        .idEx_i      (idEx),
        .fwdA_i      (fwdA),
        .fwdB_i      (fwdB),
        .memResult_i (exMem.aluOut),
        .wbResult_i  (wbResult),
        .aluOut_o    (aluOut),
        .storeData_o (storeData),
        .taken_o     (taken),
        .target_o    (target)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc            <= RESET_PC;
            ifId.valid    <= 1'b0;
            ifId.instr    <= NOP_WORD;
            idEx          <= '0;
            exMem.valid   <= 1'b0;
            exMem.ctrl    <= '0;
            memWb.valid   <= 1'b0;
            memWb.ctrl    <= '0;
        end else begin
            if (taken) begin                // flush the two younger instructions
                pc         <= target;
                ifId.valid <= 1'b0;
                ifId.instr <= NOP_WORD;
                idEx       <= '0;
            end else if (stall) begin       // hold PC and ifId
                idEx       <= '0;           // bubble
            end else begin
                pc           <= pcPlus4;
                ifId.valid   <= 1'b1;
                ifId.pcPlus4 <= pcPlus4;
                ifId.instr   <= imemInstr_i;
                idEx         <= idExNext;
            end
            exMem.valid     <= idEx.valid;
            exMem.ctrl      <= idEx.ctrl;
            exMem.dst       <= idEx.dst;
            exMem.aluOut    <= aluOut;
            exMem.storeData <= storeData;
            memWb.valid     <= exMem.valid;
            memWb.ctrl      <= exMem.ctrl;
            memWb.dst       <= exMem.dst;
            memWb.aluOut    <= exMem.aluOut;
            memWb.loadData  <= dmemRdata_i;
        end
    end

    assign dmemAddr_o  = exMem.aluOut;
    assign dmemWe_o    = exMem.valid && exMem.ctrl.memWrite;
    assign dmemWdata_o = exMem.storeData;

    assign wbResult = memWb.ctrl.memRead ? memWb.loadData : memWb.aluOut;
    assign wbEn     = memWb.valid && memWb.ctrl.regWrite;

    always_comb begin
        trace_o.valid = wbEn && memWb.dst != 5'd0;     // r0 writes are hidden
        trace_o.dst   = memWb.dst;
        trace_o.data  = wbResult;
    end

endmodule

// ==== bench/clockGen.sv ====
// ========================================
// testbench clock, 20 ns period
// and an 8-cycle synchronous reset
// ========================================
`timescale 1ns/1ps

module clockGen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;     // 20 ns period
    end

    initial begin
        reset_o <= 1'b1;
        repeat (8) @(posedge clk_o);
        reset_o <= 1'b0;                // released on a rising edge
    end

endmodule

// ==== bench/coreBench.sv ====
// ========================================
// testbench for the five-stage MIPS core
// random program checked against an ISA model
// ========================================
`timescale 1ns/1ps

module coreBench import isaPkg::*; import pipePkg::*; ();

    localparam int          PROG_LEN        = 300;
    localparam int          HALT_IDX        = PROG_LEN - 1;
    localparam logic [31:0] HALT_ADDR       = 32'(HALT_IDX * 4);
    localparam int          IMEM_WORDS      = 512;
    localparam int          DMEM_WORDS      = 64;
    localparam int          WATCHDOG_CYCLES = 8 * PROG_LEN + 100;
    localparam int          DRAIN_HITS      = 4;
    localparam logic [31:0] LFSR_SEED       = 32'h3a153d13;
    localparam logic [31:0] LFSR_TAPS       = 32'h80200003;   // x^32+x^22+x^2+x+1

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } storeT;

    logic        clk;
    logic        reset;
    logic [31:0] imemAddr;
    logic [31:0] imemInstr;
    logic [31:0] dmemAddr;
    logic        dmemWe;
    logic [31:0] dmemWdata;
    logic [31:0] dmemRdata;
    traceT       trace;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] lfsr;
    traceT       expWrites [$];
    storeT       expStores [$];
    int          settleHits;

    clockGen uClock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    mipsCore dut (
        .clk         (clk),
        .reset_i     (reset),
        .imemAddr_o  (imemAddr),
        .imemInstr_i (imemInstr),
        .dmemAddr_o  (dmemAddr),
        .dmemWe_o    (dmemWe),
        .dmemWdata_o (dmemWdata),
        .dmemRdata_i (dmemRdata),
        .trace_o     (trace)
    );

    // both memories answer in the same cycle
    assign imemInstr = imem[imemAddr[10:2]];
    assign dmemRdata = dmem[dmemAddr[7:2]];

    function automatic logic [31:0] fillWord(input int idx);
        return 32'h5eed_0000 + 32'(idx) * 32'h0001_0203;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < DMEM_WORDS; n++) begin
                dmem[n] <= fillWord(n);
            end
        end else if (dmemWe) begin
            dmem[dmemAddr[7:2]] <= dmemWdata;
        end
    end

    // one LFSR step per bit taken
    function automatic logic [31:0] randBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < width; b++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic logic [4:0] pickReg();
        return 5'(randBits(3));     // r0..r7 keeps dependencies dense
    endfunction

    function automatic logic [31:0] encR(input functE fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd);
        rTypeT w;
        w.opcode = OP_SPECIAL;
        w.rs     = rs;
        w.rt     = rt;
        w.rd     = rd;
        w.shamt  = 5'd0;
        w.funct  = fn;
        return w;
    endfunction

    function automatic logic [31:0] encI(input opcodeE op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        iTypeT w;
        w.opcode = op;
        w.rs     = rs;
        w.rt     = rt;
        w.imm    = imm;
        return w;
    endfunction

    function automatic logic [31:0] encJ(input int wordIdx);
        jTypeT w;
        w.opcode = OP_J;
        w.index  = 26'(wordIdx);
        return w;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic buildProgram();
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] offs;
        int          hop;
        for (int n = 0; n < IMEM_WORDS; n++) begin
            imem[n] = NOP_WORD;
        end
        for (int i = 0; i < HALT_IDX; i++) begin
            kind = 4'(randBits(4));
            rs   = pickReg();
            rt   = pickReg();
            rd   = pickReg();
            imm  = 16'(randBits(16));
            offs = {8'd0, 6'(randBits(6)), 2'b00};     // aligned, inside 64 words
            hop  = int'(randBits(3) % 6) + 1;
            if (i + hop > HALT_IDX) begin
                hop = HALT_IDX - i;                     // never past the halt loop
            end
            case (kind)
                4'd0, 4'd1: imem[i] = encR(FN_ADDU, rs, rt, rd);
                4'd2:       imem[i] = encR(FN_SUBU, rs, rt, rd);
                4'd3:       imem[i] = encR(FN_AND, rs, rt, rd);
                4'd4:       imem[i] = encR(FN_OR, rs, rt, rd);
                4'd5:       imem[i] = encR(FN_SLT, rs, rt, rd);
                4'd6, 4'd7: imem[i] = encI(OP_ADDIU, rs, rt, imm);
                4'd8:       imem[i] = encI(OP_ORI, rs, rt, imm);
                4'd9:       imem[i] = encI(OP_LUI, 5'd0, rt, imm);
                4'd10, 4'd11: imem[i] = encI(OP_LW, 5'd0, rt, offs);
                4'd12:      imem[i] = encI(OP_SW, 5'd0, rt, offs);
                4'd13:      imem[i] = encI(OP_BEQ, rs, rt, 16'(hop - 1));
                4'd14:      imem[i] = encI(OP_BNE, rs, rt, 16'(hop - 1));
                default:    imem[i] = encJ(i + hop);
            endcase
        end
        imem[HALT_IDX] = encI(OP_BEQ, 5'd0, 5'd0, 16'hffff);    // branch to itself
    endtask

    // sequential ISA model, no delay slots
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] mem [DMEM_WORDS];
        logic [31:0] pcM;
        logic [31:0] nextPc;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        instrU       w;
        traceT       t;
        storeT       s;
        for (int n = 0; n < 32; n++) begin
            regs[n] = '0;
        end
        for (int n = 0; n < DMEM_WORDS; n++) begin
            mem[n] = fillWord(n);
        end
        pcM = RESET_PC;
        while (pcM != HALT_ADDR) begin
            w      = imem[pcM[10:2]];
            nextPc = pcM + 32'd4;
            simm   = {{16{w.i.imm[15]}}, w.i.imm};
            addr   = regs[w.i.rs] + simm;
            dst    = w.i.rt;
            wr     = 1'b1;
            res    = '0;
            case (w.r.opcode)
                OP_SPECIAL: begin
                    dst = w.r.rd;
                    case (w.r.funct)
                        FN_ADDU: res = regs[w.r.rs] + regs[w.r.rt];
                        FN_SUBU: res = regs[w.r.rs] - regs[w.r.rt];
                        FN_AND:  res = regs[w.r.rs] & regs[w.r.rt];
                        FN_OR:   res = regs[w.r.rs] | regs[w.r.rt];
                        FN_SLT:  res = ($signed(regs[w.r.rs]) < $signed(regs[w.r.rt]))
                                       ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = regs[w.i.rs] + simm;
                OP_ORI:   res = regs[w.i.rs] | {16'h0000, w.i.imm};
                OP_LUI:   res = {w.i.imm, 16'h0000};
                OP_LW:    res = mem[addr[7:2]];
                OP_SW: begin
                    wr     = 1'b0;
                    mem[addr[7:2]] = regs[w.i.rt];
                    s.addr = addr;
                    s.data = regs[w.i.rt];
                    expStores.push_back(s);
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (regs[w.i.rs] == regs[w.i.rt]) begin
                        nextPc = pcM + 32'd4 + (simm << 2);
                    end
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (regs[w.i.rs] != regs[w.i.rt]) begin
                        nextPc = pcM + 32'd4 + (simm << 2);
                    end
                end
                OP_J: begin
                    wr     = 1'b0;
                    nextPc = {nextPc[31:28], w.j.index, 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin    // r0 stays zero and is not traced
                regs[dst] = res;
                t.valid   = 1'b1;
                t.dst     = dst;
                t.data    = res;
                expWrites.push_back(t);
            end
            pcM = nextPc;
        end
    endtask

    task automatic checkTrace(input traceT got);
        traceT exp;
        exp = expWrites.pop_front();
        if (got.dst !== exp.dst) begin
            abortRun($sformatf("MISMATCH at %0t: trace_o.dst got %0d expected %0d",
                               $time, got.dst, exp.dst));
        end else if (got.data !== exp.data) begin
            abortRun($sformatf("MISMATCH at %0t: trace_o.data got %h expected %h",
                               $time, got.data, exp.data));
        end
    endtask

    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        storeT exp;
        exp = expStores.pop_front();
        if (addr !== exp.addr) begin
            abortRun($sformatf("MISMATCH at %0t: dmemAddr_o got %h expected %h",
                               $time, addr, exp.addr));
        end else if (data !== exp.data) begin
            abortRun($sformatf("MISMATCH at %0t: dmemWdata_o got %h expected %h",
                               $time, data, exp.data));
        end
    endtask

    task automatic sampleOutputs();
        if (trace.valid) begin
            if (expWrites.size() == 0) begin
                abortRun($sformatf("extra register write to r%0d at %0t, none was expected",
                                   trace.dst, $time));
            end else begin
                checkTrace(trace);
            end
        end
        if (dmemWe) begin
            if (expStores.size() == 0) begin
                abortRun($sformatf("extra store to %h at %0t, none was expected",
                                   dmemAddr, $time));
            end else begin
                checkStore(dmemAddr, dmemWdata);
            end
        end
    endtask

    initial begin
        lfsr = LFSR_SEED;
        settleHits = 0;
        buildProgram();
        runModel();
        wait (reset == 1'b0);
        // keep checking a few halt-loop turns so late stray writes are caught
        while (settleHits < DRAIN_HITS) begin
            @(negedge clk);             // outputs settled mid-cycle
            sampleOutputs();
            if (expWrites.size() == 0 && expStores.size() == 0 && imemAddr == HALT_ADDR) begin
                settleHits++;
            end
        end
        $display("Simulation passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abortRun($sformatf("timeout after %0d cycles, the core stalled before the halt loop",
                           WATCHDOG_CYCLES));
    end

endmodule

// ==== compile.f ====
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/regFile.sv
hdl/decodeUnit.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/mipsCore.sv
bench/clockGen.sv
bench/coreBench.sv

// ==== run.sh ====
#!/bin/sh
# build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module coreBench -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VcoreBench)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation passed$"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
